// File: hw/bus_pkg.sv
/*
 * Bus word types for the 16-bit system bus: request, response
 * and the tagged address that is read as memory or as I/O
 */
`default_nettype none

package bus_pkg;

  localparam int DAT_W = 16; // Data word
  localparam int ADR_W = 19; // Byte address bits 19..1
  localparam int SEL_W = 2;  // One select per byte lane

  // Memory view of the tagged address
  typedef struct packed {
    logic             tag;   // 0 for memory
    logic [ADR_W-1:0] word;
  } mem_adr_t;

  // I/O view of the same word
  typedef struct packed {
    logic        tag;        // 1 for I/O
    logic [3:0]  rsvd;       // Not decoded on I/O cycles
    logic [14:0] port;       // Port word address, byte port >> 1
  } io_adr_t;

  typedef union packed {
    mem_adr_t mem;
    io_adr_t  io;
  } bus_adr_u;

  // CPU request as seen by every slave
  typedef struct packed {
    logic [DAT_W-1:0] dat;
    bus_adr_u         adr;
    logic [SEL_W-1:0] sel;
    logic             we;
    logic             cyc;
    logic             stb;
  } bus_req_t;

  // Slave answer
  typedef struct packed {
    logic [DAT_W-1:0] dat;
    logic             ack;
  } bus_rsp_t;

endpackage

`default_nettype wire

// File: hw/sys_map_pkg.sv
/*
 * System address map: slave numbering, address/mask windows
 * and the fixed vectors returned during interrupt acknowledge
 */
`default_nettype none

package sys_map_pkg;

  localparam int N_SLAVES = 13; // Twelve ports plus the default slave
  localparam int N_WIN    = 13; // VGA and RAM own two windows each

  typedef enum logic [3:0] {
    S_ROM   = 4'd0,
    S_VGA   = 4'd1,
    S_UART  = 4'd2,
    S_KEYB  = 4'd3,
    S_SPKR  = 4'd4,  // Reached only through the keyboard window
    S_SD    = 4'd5,
    S_GPIO  = 4'd6,
    S_CSR   = 4'd7,
    S_TIMER = 4'd8,
    S_FLASH = 4'd9,
    S_SB    = 4'd10,
    S_RAM   = 4'd11,
    S_DEF   = 4'd12
  } slave_id_e;

  // Match value is {tag, byte address[19:1]}; first hit in table order wins
  localparam logic [19:0] MAP_ADDR [N_WIN] = '{
    20'h7FF80,  // mem 0xFFF00 - 0xFFFFF, BIOS
    20'h50000,  // mem 0xA0000 - 0xBFFFF
    20'h801E0,  // io 0x3C0 - 0x3DF
    20'h801FC,  // io 0x3F8 - 0x3FF, COM1
    20'h80030,  // io 0x60 - 0x67
    20'h80080,  // io 0x100 - 0x101
    20'h87880,  // io 0xF100 - 0xF103
    20'h87900,  // io 0xF200 - 0xF20F
    20'h80020,  // io 0x40 - 0x43
    20'h8011C,  // io 0x238 - 0x23B
    20'h80108,  // io 0x210 - 0x21F
    20'h87980,  // io 0xF300 - 0xF3FF, SDRAM control
    20'h00000   // All remaining memory
  };

  localparam logic [19:0] MAP_MASK [N_WIN] = '{
    20'hFFF80, 20'hF0000, 20'h87FF0, 20'h87FFC, 20'h87FFC,
    20'h87FFF, 20'h87FFE, 20'h87FF8, 20'h87FFE, 20'h87FFE,
    20'h87FF8, 20'h87F80, 20'h80000
  };

  localparam slave_id_e MAP_SLAVE [N_WIN] = '{
    S_ROM, S_VGA, S_VGA, S_UART, S_KEYB, S_SD, S_GPIO,
    S_CSR, S_TIMER, S_FLASH, S_SB, S_RAM, S_RAM
  };

  localparam logic [15:0] NMI_VECTOR   = 16'h0002;
  localparam logic [12:0] IRQ_VEC_BASE = 13'h0001; // Vector 0x08 + iid

endpackage

`default_nettype wire

// File: hw/sys_reset_gen.sv
/*
 * Power-on reset debounce: holds the system reset for a full
 * counter period after the reset button is released
 */
`timescale 1ns/1ps
`default_nettype none

module sys_reset_gen #(
  parameter int DEBOUNCE_W = 17
) (
  input  wire  clk,
  input  wire  rst_lck,   // Active low, synchronous
  output logic rst_o
);

  logic [DEBOUNCE_W-1:0] cnt_q;

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      cnt_q <= '1;   // Any bounce restarts the hold time
      rst_o <= 1'b1;
    end else begin
      if (cnt_q != '0)
        cnt_q <= cnt_q - DEBOUNCE_W'(1);
      rst_o <= (cnt_q != '0);
    end
  end

endmodule

`default_nettype wire

// File: hw/io_addr_decoder.sv
/*
 * Address decoder: matches the tagged CPU address against the map
 * windows, splits port 0x61 off to the speaker and steers cyc/stb
 */
`timescale 1ns/1ps
`default_nettype none

module io_addr_decoder (
  input  wire                              clk,
  input  logic                             rst_i,
  input  bus_pkg::bus_req_t                req_i,
  output logic [sys_map_pkg::N_SLAVES-1:0] slv_cyc_o,
  output logic [sys_map_pkg::N_SLAVES-1:0] slv_stb_o,
  output bus_pkg::bus_rsp_t                def_rsp_o,
  output sys_map_pkg::slave_id_e           sel_id_o
);

  import sys_map_pkg::*;

  // Port 0x61 is the high byte of the word at 0x60
  localparam logic [14:0] SPKR_PORT_W = 15'h0030;

  slave_id_e hit_id;
  slave_id_e id_q;   // Last steered slave
  logic      active;

  always_comb begin
    hit_id = S_DEF;
    // Walk backwards so the lowest matching window is kept
    for (int w = N_WIN - 1; w >= 0; w--) begin
      if ((req_i.adr & MAP_MASK[w]) == MAP_ADDR[w])
        hit_id = MAP_SLAVE[w];
    end
    if (hit_id == S_KEYB && req_i.adr.io.port == SPKR_PORT_W && req_i.sel[1])
      hit_id = S_SPKR;
  end

  assign active = req_i.cyc & ~rst_i;

  always_comb begin
    slv_cyc_o = '0;
    slv_stb_o = '0;
    if (active) begin
      slv_cyc_o[hit_id] = 1'b1;
      slv_stb_o[hit_id] = req_i.stb;
    end
  end

  // Keeps the return path on the last slave between cycles
  always_ff @(posedge clk) begin
    if (rst_i)
      id_q <= S_DEF;
    else if (active)
      id_q <= hit_id;
  end

  assign sel_id_o = active ? hit_id : id_q;

  // Default slave answers at once with zero data
  assign def_rsp_o.dat = '0;
  assign def_rsp_o.ack = slv_cyc_o[S_DEF] & slv_stb_o[S_DEF];

endmodule

`default_nettype wire

// File: hw/simple_pic.sv
/*
 * Simple interrupt controller: rising edges set pending bits,
 * the lowest pending line is handed out on interrupt acknowledge
 */
`timescale 1ns/1ps
`default_nettype none

module simple_pic #(
  parameter int N_IRQ = 8
) (
  input  wire              clk,
  input  logic             rst_i,
  input  logic [N_IRQ-1:0] intv_i,
  input  logic             inta_i,
  output logic             intr_o,
  output logic [2:0]       iid_o
);

  logic [N_IRQ-1:0] intv_q;
  logic [N_IRQ-1:0] pend_q;
  logic [N_IRQ-1:0] clr;
  logic [2:0]       pick;
  logic             inta_q;
  logic             inta_rise;

  assign inta_rise = inta_i & ~inta_q;

  // Priority encoder, line 0 highest
  always_comb begin
    pick = '0;
    clr  = '0;
    for (int i = N_IRQ - 1; i >= 0; i--) begin
      if (pend_q[i])
        pick = 3'(i);
    end
    if (inta_rise && pend_q != '0)
      clr[pick] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      intv_q <= '0;
      pend_q <= '0;
      inta_q <= 1'b0;
      intr_o <= 1'b0;
      iid_o  <= '0;
    end else begin
      intv_q <= intv_i;
      inta_q <= inta_i;
      pend_q <= (pend_q & ~clr) | (intv_i & ~intv_q);
      intr_o <= (pend_q != '0);
      if (inta_rise)
        iid_o <= pick; // Stable until the next acknowledge
    end
  end

endmodule

`default_nettype wire

// File: hw/bus_return_mux.sv
/*
 * Read-return stage: picks the addressed slave's ack and data and
 * replaces the data with the NMI or interrupt vector on acknowledge
 */
`timescale 1ns/1ps
`default_nettype none

module bus_return_mux (
  input  sys_map_pkg::slave_id_e                         sel_id_i,
  input  bus_pkg::bus_rsp_t [sys_map_pkg::N_SLAVES-2:0]  slv_rsp_i,
  input  bus_pkg::bus_rsp_t                              def_rsp_i,
  input  logic                                           inta_i,
  input  logic                                           nmia_i,
  input  logic [2:0]                                     iid_i,
  output bus_pkg::bus_rsp_t                              cpu_rsp_o
);

  import sys_map_pkg::*;

  always_comb begin
    cpu_rsp_o = def_rsp_i; // S_DEF has no entry in slv_rsp_i
    for (int s = 0; s < N_SLAVES - 1; s++) begin
      if (sel_id_i == slave_id_e'(s))
        cpu_rsp_o = slv_rsp_i[s];
    end

    // Vector reads still end on the slave's ack
    if (nmia_i)
      cpu_rsp_o.dat = NMI_VECTOR;
    else if (inta_i)
      cpu_rsp_o.dat = {IRQ_VEC_BASE, iid_i};
  end

endmodule

`default_nettype wire

// File: hw/sys_bus_top.sv
/*
 * System bus glue: reset debounce, address decode, interrupt
 * controller and the read-return path to the CPU
 */
`timescale 1ns/1ps
`default_nettype none

module sys_bus_top #(
  parameter int DEBOUNCE_W = 17,
  parameter int N_IRQ      = 8
) (
  input  wire                                            clk,
  input  wire                                            rst_lck,
  input  bus_pkg::bus_req_t                              cpu_req_i,
  output bus_pkg::bus_rsp_t                              cpu_rsp_o,
  output bus_pkg::bus_req_t                              slv_req_o,
  output logic [sys_map_pkg::N_SLAVES-1:0]               slv_cyc_o,
  output logic [sys_map_pkg::N_SLAVES-1:0]               slv_stb_o,
  input  bus_pkg::bus_rsp_t [sys_map_pkg::N_SLAVES-2:0]  slv_rsp_i,
  input  logic [N_IRQ-1:0]                               intv_i,
  output logic                                           intr_o,
  input  logic                                           inta_i,
  input  logic                                           nmia_i,
  output logic                                           rst_o
);

  import bus_pkg::*;
  import sys_map_pkg::*;

  bus_rsp_t   def_rsp;
  slave_id_e  sel_id;
  logic [2:0] iid;

  // Shared request, per-slave strobes come from the decoder
  assign slv_req_o = '{dat: cpu_req_i.dat, adr: cpu_req_i.adr, sel: cpu_req_i.sel,
                       we: cpu_req_i.we, cyc: 1'b0, stb: 1'b0};

  sys_reset_gen #(
    .DEBOUNCE_W (DEBOUNCE_W)
  ) u_reset (
    .clk     (clk),
    .rst_lck (rst_lck),
    .rst_o   (rst_o)
  );

  io_addr_decoder u_decoder (
    .clk       (clk),
    .rst_i     (rst_o),
    .req_i     (cpu_req_i),
    .slv_cyc_o (slv_cyc_o),
    .slv_stb_o (slv_stb_o),
    .def_rsp_o (def_rsp),
    .sel_id_o  (sel_id)
  );

  simple_pic #(
    .N_IRQ (N_IRQ)
  ) u_pic (
    .clk    (clk),
    .rst_i  (rst_o),
    .intv_i (intv_i),
    .inta_i (inta_i),
    .intr_o (intr_o),
    .iid_o  (iid)
  );

  bus_return_mux u_return (
    .sel_id_i  (sel_id),
    .slv_rsp_i (slv_rsp_i),
    .def_rsp_i (def_rsp),
    .inta_i    (inta_i),
    .nmia_i    (nmia_i),
    .iid_i     (iid),
    .cpu_rsp_o (cpu_rsp_o)
  );

endmodule

`default_nettype wire

// File: test/tb_sys_bus.sv
/*
 * Testbench for the system bus glue: reset hold time, window decode
 * from the case file, interrupt acknowledge and NMI vector reads
 */
`timescale 1ns/1ps
`default_nettype none

module tb_sys_bus;

  import bus_pkg::*;
  import sys_map_pkg::*;

  localparam int       TIMEOUT = 20;  // Cycles allowed for any single wait
  localparam bus_req_t IDLE    = '0;

  logic                       clk;
  logic                       rst_lck;
  bus_req_t                   cpu_req;
  bus_rsp_t                   cpu_rsp;
  bus_req_t                   slv_req;
  logic [N_SLAVES-1:0]        slv_cyc;
  logic [N_SLAVES-1:0]        slv_stb;
  bus_rsp_t [N_SLAVES-2:0]    slv_rsp;
  logic [7:0]                 intv;
  logic                       intr;
  logic                       inta;
  logic                       nmia;
  logic                       rst_o;
  logic [N_SLAVES-2:0]        ack_q;

  int                         seed;
  int                         test_errs;
  int                         passes;
  int                         fails;
  int                         fd;
  int                         n;
  int                         hi_cycles;
  int                         n_cases;
  logic                       done;
  logic                       seen;
  reg   [8*96-1:0]            line_buf;
  reg   [8*16-1:0]            name_r;
  string                      case_name;
  logic                       tag_r;
  logic [18:0]                word_r;
  logic [1:0]                 sel_r;
  int                         slave_r;
  logic [15:0]                data_r;
  logic [15:0]                rd_dat;
  logic [N_SLAVES-1:0]        cyc_seen;
  logic [N_SLAVES-1:0]        stb_seen;
  logic [N_SLAVES-1:0]        exp_cyc;
  logic                       got_ack;

  sys_bus_top #(
    .DEBOUNCE_W (4),
    .N_IRQ      (8)
  ) DUT (
    .clk       (clk),
    .rst_lck   (rst_lck),
    .cpu_req_i (cpu_req),
    .cpu_rsp_o (cpu_rsp),
    .slv_req_o (slv_req),
    .slv_cyc_o (slv_cyc),
    .slv_stb_o (slv_stb),
    .slv_rsp_i (slv_rsp),
    .intv_i    (intv),
    .intr_o    (intr),
    .inta_i    (inta),
    .nmia_i    (nmia),
    .rst_o     (rst_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Slave models ack one cycle after being steered, single ack per transfer
  always_ff @(posedge clk) begin
    if (rst_o)
      ack_q <= '0;
    else
      ack_q <= slv_cyc[N_SLAVES-2:0] & slv_stb[N_SLAVES-2:0] & ~ack_q;
  end

  always_comb begin
    for (int s = 0; s < N_SLAVES - 1; s++) begin
      slv_rsp[s].dat = 16'hA000 + 16'(s); // Slave number in the low bits
      slv_rsp[s].ack = ack_q[s];
    end
  end

  function automatic bus_req_t make_req(input logic tag, input logic [18:0] word,
                                        input logic [1:0] sel);
    bus_req_t r;
    r              = '0;
    r.adr.mem.tag  = tag;
    r.adr.mem.word = word;
    r.sel          = sel;
    r.cyc          = 1'b1;
    r.stb          = 1'b1;
    return r;
  endfunction

  // One read transfer, ends on the CPU-side ack or the timeout
  task automatic bus_read(input string name, input logic tag, input logic [18:0] word,
                          input logic [1:0] sel, input logic inta_v, input logic nmia_v,
                          output logic [15:0] dat, output logic [N_SLAVES-1:0] cyc_o,
                          output logic [N_SLAVES-1:0] stb_o, output logic ack_seen);
    bus_req_t req;
    req     = make_req(tag, word, sel);
    req.dat = 16'($random(seed)); // Random payload on the shared request
    @(posedge clk);
    cpu_req <= req;
    inta    <= inta_v;
    nmia    <= nmia_v;
    ack_seen = 1'b0;
    for (int i = 0; i < TIMEOUT; i++) begin
      @(negedge clk);
      if (cpu_rsp.ack) begin
        ack_seen = 1'b1;
        break;
      end
    end
    dat   = cpu_rsp.dat;
    cyc_o = slv_cyc;
    stb_o = slv_stb;
    if (ack_seen && {slv_req.dat, slv_req.adr, slv_req.sel, slv_req.we} !==
                    {req.dat, req.adr, req.sel, req.we}) begin
      $display("Mismatch %s: expected %h, actual %h", name,
               {req.dat, req.adr, req.sel, req.we},
               {slv_req.dat, slv_req.adr, slv_req.sel, slv_req.we});
      test_errs++;
    end
    @(posedge clk);
    cpu_req <= IDLE;
    inta    <= 1'b0;
    nmia    <= 1'b0;
  endtask

  task automatic check_read(input string name, input logic tag, input logic [18:0] word,
                            input logic [1:0] sel, input logic inta_v, input logic nmia_v,
                            input logic [15:0] exp_dat);
    logic [15:0]         dat;
    logic [N_SLAVES-1:0] cyc_o;
    logic [N_SLAVES-1:0] stb_o;
    logic                ack_seen;
    bus_read(name, tag, word, sel, inta_v, nmia_v, dat, cyc_o, stb_o, ack_seen);
    if (!ack_seen) begin
      $display("%s: no ack within %0d cycles", name, TIMEOUT);
      test_errs++;
    end else if (dat !== exp_dat) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp_dat, dat);
      test_errs++;
    end
  endtask

  task automatic wait_intr(input logic level, output logic ok);
    ok = 1'b0;
    for (int i = 0; i < TIMEOUT; i++) begin
      @(negedge clk);
      if (intr === level) begin
        ok = 1'b1;
        break;
      end
    end
  endtask

  task automatic report_test(input string name);
    if (test_errs == 0) begin
      passes++;
      $display("test %s: ok", name);
    end else begin
      fails++;
      $display("test %s: %0d error(s)", name, test_errs);
    end
  endtask

  initial begin
    cpu_req = IDLE;
    rst_lck = 1'b0;
    intv    = '0;
    inta    = 1'b0;
    nmia    = 1'b0;
    seed    = 32'h124a_6095;
    passes  = 0;
    fails   = 0;
    n_cases = 0;

    // Reset with a RAM cycle pending, which must stay unsteered
    test_errs = 0;
    @(posedge clk);
    cpu_req <= make_req(1'b0, 19'h0, 2'b11);
    @(posedge clk);
    intv    <= 8'hFF;  // Edges seen during reset leave nothing pending
    @(posedge clk);
    rst_lck <= 1'b1;
    @(posedge clk);   // First edge that sees rst_lck high
    intv      <= '0;
    hi_cycles = 0;
    done      = 1'b0;
    for (int i = 0; i < 64; i++) begin
      @(negedge clk);
      if (!rst_o) begin
        done = 1'b1;
        break;
      end
      hi_cycles++;
      if (slv_cyc != '0) begin
        $display("slave cyc high while rst_o is high");
        test_errs++;
      end
      if (intr !== 1'b0) begin
        $display("intr_o high while rst_o is high");
        test_errs++;
      end
      @(posedge clk);
    end
    if (!done) begin
      $display("rst_o never fell after rst_lck released");
      test_errs++;
    end else if (hi_cycles != 15) begin
      $display("Mismatch reset: expected %0d, actual %0d", 15, hi_cycles);
      test_errs++;
    end
    @(posedge clk);
    cpu_req <= IDLE;
    done = 1'b0;
    for (int i = 0; i < TIMEOUT; i++) begin
      @(negedge clk);
      if (!cpu_rsp.ack && ack_q == '0) begin
        done = 1'b1;
        break;
      end
    end
    if (!done) begin
      $display("bus did not go idle after reset");
      test_errs++;
    end
    report_test("reset");

    // Decode cases from the data file
    fd = $fopen("test/bus_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open test/bus_cases.txt");
      fails++;
    end else begin
      for (int line = 0; line < 256; line++) begin
        if ($feof(fd))
          break;
        n = $fgets(line_buf, fd);
        if (n == 0)
          break;
        n = $sscanf(line_buf, "%s %h %h %h %d %h",
                    name_r, tag_r, word_r, sel_r, slave_r, data_r);
        if (n != 6)
          continue;  // Header or blank line
        n_cases++;
        case_name = $sformatf("%0s", name_r);
        test_errs = 0;
        bus_read(case_name, tag_r, word_r, sel_r, 1'b0, 1'b0,
                 rd_dat, cyc_seen, stb_seen, got_ack);
        exp_cyc = N_SLAVES'(1) << slave_r;
        if (!got_ack) begin
          $display("%s: no ack within %0d cycles", case_name, TIMEOUT);
          test_errs++;
        end else begin
          if (cyc_seen !== exp_cyc) begin
            $display("Mismatch %s: expected %b, actual %b", case_name, exp_cyc, cyc_seen);
            test_errs++;
          end
          if (stb_seen !== exp_cyc) begin
            $display("Mismatch %s: expected %b, actual %b", case_name, exp_cyc, stb_seen);
            test_errs++;
          end
          if (rd_dat !== data_r) begin
            $display("Mismatch %s: expected %h, actual %h", case_name, data_r, rd_dat);
            test_errs++;
          end
        end
        report_test(case_name);
      end
      $fclose(fd);
      if (n_cases == 0) begin
        $display("no decode cases found in test/bus_cases.txt");
        fails++;
      end
    end

    // Lines 3 and 1 together, line 1 is served first
    test_errs = 0;
    @(posedge clk);
    intv <= 8'b0000_1010;
    wait_intr(1'b1, seen);
    if (!seen) begin
      $display("intr_o did not rise after interrupt lines were raised");
      test_errs++;
    end
    check_read("irq_first", 1'b0, 19'h0, 2'b11, 1'b1, 1'b0, 16'h0008 + 16'd1);
    check_read("irq_second", 1'b0, 19'h0, 2'b11, 1'b1, 1'b0, 16'h0008 + 16'd3);
    wait_intr(1'b0, seen);
    if (!seen) begin
      $display("intr_o stayed high after both interrupts were acknowledged");
      test_errs++;
    end
    @(posedge clk);
    intv <= '0;
    report_test("interrupts");

    // NMI vector over ROM, COM1 and an unmapped port
    test_errs = 0;
    check_read("nmi_rom", 1'b0, 19'h7FF80, 2'b11, 1'b0, 1'b1, 16'h0002);
    check_read("nmi_com1", 1'b1, 19'h001FC, 2'b01, 1'b0, 1'b1, 16'h0002);
    check_read("nmi_unmapped", 1'b1, 19'h00180, 2'b11, 1'b0, 1'b1, 16'h0002);
    report_test("nmi");

    $display("tests: %0d passed, %0d failed", passes, fails);
    if (fails == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/bus_cases.txt
# Decode cases, one per line, values after the name in hex except slave
# name tag word_adr sel slave(decimal) read_data
rom_lo     0 7FF80 3 0  A000
rom_hi     0 7FFFF 3 0  A000
vga_mem    0 50000 3 1  A001
vga_text   0 5C000 3 1  A001
vga_io     1 001E0 3 1  A001
vga_stat   1 001ED 1 1  A001
com1       1 001FC 1 2  A002
com1_lsr   1 001FE 2 2  A002
keyb_60    1 00030 1 3  A003
spkr_61    1 00030 2 4  A004
keyb_64    1 00032 1 3  A003
sd         1 00080 3 5  A005
gpio       1 07880 3 6  A006
csr        1 07900 3 7  A007
csr_hi     1 07907 3 7  A007
timer      1 00020 1 8  A008
timer_42   1 00021 1 8  A008
flash      1 0011C 3 9  A009
sb         1 00108 3 10 A00A
sb_hi      1 0010F 3 10 A00A
ram_ctl    1 07980 3 11 A00B
ram_low    0 00000 3 11 A00B
ram_mid    0 091A0 3 11 A00B
ram_c0000  0 60000 3 11 A00B
unmap_300  1 00180 3 12 0000
unmap_80   1 00040 3 12 0000

// File: src.f
hw/bus_pkg.sv
hw/sys_map_pkg.sv
hw/sys_reset_gen.sv
hw/io_addr_decoder.sv
hw/simple_pic.sv
hw/bus_return_mux.sv
hw/sys_bus_top.sv
test/tb_sys_bus.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the system bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f src.f --top-module tb_sys_bus \
    -Mdir obj_dir -o sim_tb; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_tb)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TB PASSED"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1
